// ==== logic/uart_config.svh ====
// ------------------------------------------------
// UART peripheral sizing macros
// Character width, AXI4-Lite bus widths, baud
// divisor width and its reset value
// ------------------------------------------------

`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// Character width in bits
`define UART_DATA_W   8

// AXI4-Lite bus, eight word registers
`define UART_AXIL_AW  5
`define UART_AXIL_DW  32

// Bit time is (divisor + 1) clock cycles
`define UART_BAUD_W   16
`define UART_BAUD_RST 7

`endif

// ==== logic/uart_pkg.sv ====
// ------------------------------------------------
// UART shared types: register index, FSM states
// and AXI response codes
// ------------------------------------------------

package uart_pkg;

    // Word index from address bits 4:2, 6 and 7 unmapped
    typedef enum logic [2:0] {
        REG_TXDATA   = 3'd0,
        REG_RXDATA   = 3'd1,
        REG_BAUD     = 3'd2,
        REG_CTRL     = 3'd3,
        REG_STATUS   = 3'd4,
        REG_INT_MASK = 3'd5
    } uart_reg_e;

    typedef enum logic [1:0] {
        TX_IDLE, TX_START, TX_DATA, TX_STOP
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE, RX_START, RX_DATA, RX_STOP
    } rx_state_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

endpackage

// ==== logic/uart_axil_regs.sv ====
// ------------------------------------------------
// AXI4-Lite slave register block for the UART
// Register file, sticky status, TX pulse and IRQ
// ------------------------------------------------
`timescale 1ns/1ns
`include "uart_config.svh"

module uart_axil_regs (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`UART_AXIL_AW-1:0]    s_axil_awaddr_i,
    input  logic                        s_axil_awvalid_i,
    output logic                        s_axil_awready_o,
    input  logic [`UART_AXIL_DW-1:0]    s_axil_wdata_i,
    input  logic                        s_axil_wvalid_i,
    output logic                        s_axil_wready_o,
    output uart_pkg::axil_resp_e        s_axil_bresp_o,
    output logic                        s_axil_bvalid_o,
    input  logic                        s_axil_bready_i,
    input  logic [`UART_AXIL_AW-1:0]    s_axil_araddr_i,
    input  logic                        s_axil_arvalid_i,
    output logic                        s_axil_arready_o,
    output logic [`UART_AXIL_DW-1:0]    s_axil_rdata_o,
    output uart_pkg::axil_resp_e        s_axil_rresp_o,
    output logic                        s_axil_rvalid_o,
    input  logic                        s_axil_rready_i,
    output logic [`UART_DATA_W-1:0]     tx_data_o,
    output logic                        tx_valid_o,
    output logic                        two_stop_o,
    output logic [`UART_BAUD_W-1:0]     baud_div_o,
    input  logic                        tx_ready_i,
    input  logic [`UART_DATA_W-1:0]     rx_data_i,
    input  logic                        rx_valid_i,
    input  logic                        rx_frame_err_i,
    output logic                        irq_o
);
    import uart_pkg::*;

    uart_reg_e                  wr_idx;
    uart_reg_e                  rd_idx;
    logic                       wr_fire;
    logic                       rd_fire;
    axil_resp_e                 wr_resp;
    axil_resp_e                 rd_resp;
    logic [`UART_AXIL_DW-1:0]   rd_data;

    logic [`UART_DATA_W-1:0]    rx_byte_q;
    logic                       rx_held_q;
    logic                       frame_err_q;
    logic                       overrun_q;
    logic [3:0]                 int_mask_q;
    logic [3:0]                 status;
    logic                       tx_busy;
    logic                       rx_read;

    // ------------------------------------------------
    // Handshake and decode
    // ------------------------------------------------
    assign wr_idx  = uart_reg_e'(s_axil_awaddr_i[4:2]);
    assign rd_idx  = uart_reg_e'(s_axil_araddr_i[4:2]);
    assign wr_fire = s_axil_awvalid_i & s_axil_wvalid_i & ~s_axil_bvalid_o;
    assign rd_fire = s_axil_arvalid_i & ~s_axil_rvalid_o;
    assign rx_read = rd_fire & (rd_idx == REG_RXDATA);

    assign s_axil_awready_o = wr_fire;
    assign s_axil_wready_o  = wr_fire;
    assign s_axil_arready_o = rd_fire;

    // A byte waiting for the transmitter counts as busy
    assign tx_busy = ~tx_ready_i | tx_valid_o;
    assign status  = {overrun_q, frame_err_q, rx_held_q, ~tx_busy};

    always_comb begin
        wr_resp = RESP_OKAY;
        case (wr_idx)
            REG_TXDATA, REG_RXDATA, REG_BAUD,
            REG_CTRL, REG_STATUS, REG_INT_MASK: wr_resp = RESP_OKAY;
            default: wr_resp = RESP_SLVERR;
        endcase
    end

    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (rd_idx)
            REG_TXDATA: rd_data[`UART_AXIL_DW-1] = tx_busy;
            REG_RXDATA: begin
                rd_data[`UART_AXIL_DW-1]  = ~rx_held_q;
                rd_data[`UART_DATA_W-1:0] = rx_byte_q;
            end
            REG_BAUD:     rd_data[`UART_BAUD_W-1:0] = baud_div_o;
            REG_CTRL:     rd_data[0] = two_stop_o;
            REG_STATUS:   rd_data[3:0] = status;
            REG_INT_MASK: rd_data[3:0] = int_mask_q;
            default:      rd_resp = RESP_SLVERR;
        endcase
    end

    // ------------------------------------------------
    // Register file and status
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_axil_bvalid_o <= 1'b0;
            s_axil_bresp_o  <= RESP_OKAY;
            s_axil_rvalid_o <= 1'b0;
            s_axil_rresp_o  <= RESP_OKAY;
            s_axil_rdata_o  <= '0;
            tx_valid_o      <= 1'b0;
            baud_div_o      <= `UART_BAUD_W'(`UART_BAUD_RST);
            two_stop_o      <= 1'b0;
            int_mask_q      <= '0;
            rx_byte_q       <= '0;
            rx_held_q       <= 1'b0;
            frame_err_q     <= 1'b0;
            overrun_q       <= 1'b0;
            irq_o           <= 1'b0;
        end else begin
            tx_valid_o <= 1'b0;
            if (wr_fire) begin
                s_axil_bvalid_o <= 1'b1;
                s_axil_bresp_o  <= wr_resp;
                case (wr_idx)
                    REG_TXDATA:   tx_valid_o <= 1'b1;
                    REG_BAUD:     baud_div_o <= s_axil_wdata_i[`UART_BAUD_W-1:0];
                    REG_CTRL:     two_stop_o <= s_axil_wdata_i[0];
                    REG_INT_MASK: int_mask_q <= s_axil_wdata_i[3:0];
                    REG_STATUS: begin
                        // Write one to clear the sticky errors
                        if (s_axil_wdata_i[2]) frame_err_q <= 1'b0;
                        if (s_axil_wdata_i[3]) overrun_q <= 1'b0;
                    end
                    default: ;
                endcase
            end else if (s_axil_bready_i) begin
                s_axil_bvalid_o <= 1'b0;
            end

            if (rd_fire) begin
                s_axil_rvalid_o <= 1'b1;
                s_axil_rdata_o  <= rd_data;
                s_axil_rresp_o  <= rd_resp;
            end else if (s_axil_rready_i) begin
                s_axil_rvalid_o <= 1'b0;
            end

            // New byte wins over a read clearing the held flag
            if (rx_valid_i) begin
                rx_byte_q <= rx_data_i;
                rx_held_q <= 1'b1;
                if (rx_held_q && !rx_read) overrun_q <= 1'b1;
            end else if (rx_read) begin
                rx_held_q <= 1'b0;
            end
            if (rx_frame_err_i) frame_err_q <= 1'b1;

            irq_o <= |(status & int_mask_q);
        end
    end

    // Byte offered to the transmitter
    always_ff @(posedge clk) begin
        if (wr_fire && wr_idx == REG_TXDATA) begin
            tx_data_o <= s_axil_wdata_i[`UART_DATA_W-1:0];
        end
    end

endmodule

// ==== logic/uart_tx.sv ====
// ------------------------------------------------
// UART serial transmitter
// Start bit, 8 data bits LSB first, 1 or 2 stops
// ------------------------------------------------
`timescale 1ns/1ns
`include "uart_config.svh"

module uart_tx (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`UART_DATA_W-1:0]     tx_data_i,
    input  logic                        tx_valid_i,
    output logic                        tx_ready_o,
    input  logic [`UART_BAUD_W-1:0]     baud_div_i,
    input  logic                        two_stop_i,
    output logic                        txd_o
);
    import uart_pkg::*;

    localparam int IDX_W = $clog2(`UART_DATA_W);

    tx_state_e                  state_q;
    logic [`UART_BAUD_W-1:0]    cnt_q;
    logic [IDX_W-1:0]           bit_idx_q;
    logic [`UART_DATA_W-1:0]    shift_q;
    logic                       two_stop_q;
    logic                       stop2_q;
    logic                       bit_done;
    logic                       xfer;

    assign tx_ready_o = (state_q == TX_IDLE);
    assign xfer       = tx_valid_i & tx_ready_o;
    assign bit_done   = (cnt_q == baud_div_i);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= TX_IDLE;
            cnt_q      <= '0;
            bit_idx_q  <= '0;
            two_stop_q <= 1'b0;
            stop2_q    <= 1'b0;
            txd_o      <= 1'b1;
        end else begin
            cnt_q <= (bit_done || state_q == TX_IDLE) ? '0 : cnt_q + 1'b1;
            case (state_q)
                TX_IDLE: if (xfer) begin
                    state_q    <= TX_START;
                    txd_o      <= 1'b0;
                    two_stop_q <= two_stop_i;
                    stop2_q    <= 1'b0;
                end
                TX_START: if (bit_done) begin
                    state_q   <= TX_DATA;
                    txd_o     <= shift_q[0];
                    bit_idx_q <= '0;
                end
                TX_DATA: if (bit_done) begin
                    if (bit_idx_q == IDX_W'(`UART_DATA_W - 1)) begin
                        state_q <= TX_STOP;
                        txd_o   <= 1'b1;
                    end else begin
                        txd_o     <= shift_q[1];
                        bit_idx_q <= bit_idx_q + 1'b1;
                    end
                end
                TX_STOP: if (bit_done) begin
                    if (two_stop_q && !stop2_q) stop2_q <= 1'b1;
                    else state_q <= TX_IDLE;
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // Shift register, bit 0 is the next data bit on the line
    always_ff @(posedge clk) begin
        if (xfer) shift_q <= tx_data_i;
        else if (state_q == TX_DATA && bit_done) shift_q <= shift_q >> 1;
    end

endmodule

// ==== logic/uart_rx.sv ====
// ------------------------------------------------
// UART serial receiver
// Input synchronizer, mid-bit sampling, stop check
// ------------------------------------------------
`timescale 1ns/1ns
`include "uart_config.svh"

module uart_rx (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        rxd_i,
    input  logic [`UART_BAUD_W-1:0]     baud_div_i,
    output logic [`UART_DATA_W-1:0]     rx_data_o,
    output logic                        rx_valid_o,
    output logic                        rx_frame_err_o
);
    import uart_pkg::*;

    localparam int IDX_W = $clog2(`UART_DATA_W);

    rx_state_e                  state_q;
    logic                       rxd_s1;
    logic                       rxd_s2;
    logic                       rxd_prev;
    logic [`UART_BAUD_W-1:0]    cnt_q;
    logic [IDX_W-1:0]           bit_idx_q;
    logic [`UART_DATA_W-1:0]    shift_q;
    logic                       half_done;
    logic                       bit_done;

    assign half_done = (cnt_q == (baud_div_i >> 1));
    assign bit_done  = (cnt_q == baud_div_i);

    // Two flop synchronizer plus one for edge detect
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_s1   <= 1'b1;
            rxd_s2   <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_s1   <= rxd_i;
            rxd_s2   <= rxd_s1;
            rxd_prev <= rxd_s2;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q        <= RX_IDLE;
            cnt_q          <= '0;
            bit_idx_q      <= '0;
            rx_valid_o     <= 1'b0;
            rx_frame_err_o <= 1'b0;
        end else begin
            rx_valid_o     <= 1'b0;
            rx_frame_err_o <= 1'b0;
            cnt_q          <= cnt_q + 1'b1;
            case (state_q)
                RX_IDLE: begin
                    cnt_q <= '0;
                    if (rxd_prev && !rxd_s2) state_q <= RX_START;
                end
                // Confirm the start bit at its middle
                RX_START: if (half_done) begin
                    cnt_q     <= '0;
                    bit_idx_q <= '0;
                    state_q   <= rxd_s2 ? RX_IDLE : RX_DATA;
                end
                RX_DATA: if (bit_done) begin
                    cnt_q     <= '0;
                    bit_idx_q <= bit_idx_q + 1'b1;
                    if (bit_idx_q == IDX_W'(`UART_DATA_W - 1)) state_q <= RX_STOP;
                end
                RX_STOP: if (bit_done) begin
                    state_q        <= RX_IDLE;
                    rx_valid_o     <= rxd_s2;
                    rx_frame_err_o <= ~rxd_s2;
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // Byte assembly, LSB arrives first
    always_ff @(posedge clk) begin
        if (state_q == RX_DATA && bit_done) shift_q <= {rxd_s2, shift_q[`UART_DATA_W-1:1]};
        if (state_q == RX_STOP && bit_done && rxd_s2) rx_data_o <= shift_q;
    end

endmodule

// ==== logic/uart_top.sv ====
// ------------------------------------------------
// UART peripheral top level
// AXI4-Lite register block with TX and RX engines
// ------------------------------------------------
`timescale 1ns/1ns
`include "uart_config.svh"

module uart_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`UART_AXIL_AW-1:0]    s_axil_awaddr_i,
    input  logic                        s_axil_awvalid_i,
    output logic                        s_axil_awready_o,
    input  logic [`UART_AXIL_DW-1:0]    s_axil_wdata_i,
    input  logic                        s_axil_wvalid_i,
    output logic                        s_axil_wready_o,
    output logic [1:0]                  s_axil_bresp_o,
    output logic                        s_axil_bvalid_o,
    input  logic                        s_axil_bready_i,
    input  logic [`UART_AXIL_AW-1:0]    s_axil_araddr_i,
    input  logic                        s_axil_arvalid_i,
    output logic                        s_axil_arready_o,
    output logic [`UART_AXIL_DW-1:0]    s_axil_rdata_o,
    output logic [1:0]                  s_axil_rresp_o,
    output logic                        s_axil_rvalid_o,
    input  logic                        s_axil_rready_i,
    input  logic                        uart_rxd_i,
    output logic                        uart_txd_o,
    output logic                        uart_irq_o
);

    logic [`UART_DATA_W-1:0]    tx_data;
    logic                       tx_valid;
    logic                       tx_ready;
    logic [`UART_BAUD_W-1:0]    baud_div;
    logic                       two_stop;
    logic [`UART_DATA_W-1:0]    rx_data;
    logic                       rx_valid;
    logic                       rx_frame_err;

    uart_axil_regs u_regs (
        .clk              (clk),
        .rst_n            (rst_n),
        .s_axil_awaddr_i  (s_axil_awaddr_i),
        .s_axil_awvalid_i (s_axil_awvalid_i),
        .s_axil_awready_o (s_axil_awready_o),
        .s_axil_wdata_i   (s_axil_wdata_i),
        .s_axil_wvalid_i  (s_axil_wvalid_i),
        .s_axil_wready_o  (s_axil_wready_o),
        .s_axil_bresp_o   (s_axil_bresp_o),
        .s_axil_bvalid_o  (s_axil_bvalid_o),
        .s_axil_bready_i  (s_axil_bready_i),
        .s_axil_araddr_i  (s_axil_araddr_i),
        .s_axil_arvalid_i (s_axil_arvalid_i),
        .s_axil_arready_o (s_axil_arready_o),
        .s_axil_rdata_o   (s_axil_rdata_o),
        .s_axil_rresp_o   (s_axil_rresp_o),
        .s_axil_rvalid_o  (s_axil_rvalid_o),
        .s_axil_rready_i  (s_axil_rready_i),
        .tx_data_o        (tx_data),
        .tx_valid_o       (tx_valid),
        .two_stop_o       (two_stop),
        .baud_div_o       (baud_div),
        .tx_ready_i       (tx_ready),
        .rx_data_i        (rx_data),
        .rx_valid_i       (rx_valid),
        .rx_frame_err_i   (rx_frame_err),
        .irq_o            (uart_irq_o)
    );

    uart_tx u_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .tx_data_i  (tx_data),
        .tx_valid_i (tx_valid),
        .tx_ready_o (tx_ready),
        .baud_div_i (baud_div),
        .two_stop_i (two_stop),
        .txd_o      (uart_txd_o)
    );

    uart_rx u_rx (
        .clk            (clk),
        .rst_n          (rst_n),
        .rxd_i          (uart_rxd_i),
        .baud_div_i     (baud_div),
        .rx_data_o      (rx_data),
        .rx_valid_o     (rx_valid),
        .rx_frame_err_o (rx_frame_err)
    );

endmodule

// ==== dv/uart_tb.sv ====
// ------------------------------------------------
// UART peripheral testbench
// Clock, reset, AXI4-Lite bus tasks, loopback mux,
// directed tests and cycle timeout
// ------------------------------------------------
`timescale 1ns/1ns
`include "uart_config.svh"

module uart_tb;
    import uart_pkg::*;

    localparam int BUS_WAIT   = 16;
    localparam int LOOP_BYTES = 4;
    localparam int LOOP_BAUD  = 7;
    localparam int ERR_BAUD   = 7;

    logic                       clk;
    logic                       rst_n;
    logic [`UART_AXIL_AW-1:0]   s_axil_awaddr;
    logic                       s_axil_awvalid;
    logic                       s_axil_awready;
    logic [`UART_AXIL_DW-1:0]   s_axil_wdata;
    logic                       s_axil_wvalid;
    logic                       s_axil_wready;
    logic [1:0]                 s_axil_bresp;
    logic                       s_axil_bvalid;
    logic                       s_axil_bready;
    logic [`UART_AXIL_AW-1:0]   s_axil_araddr;
    logic                       s_axil_arvalid;
    logic                       s_axil_arready;
    logic [`UART_AXIL_DW-1:0]   s_axil_rdata;
    logic [1:0]                 s_axil_rresp;
    logic                       s_axil_rvalid;
    logic                       s_axil_rready;
    logic                       loopback;
    logic                       rxd_drive;
    logic                       uart_rxd;
    logic                       uart_txd;
    logic                       uart_irq;

    int cycle = 0;
    int cycle_limit = 0;
    int acc_cycle = 0;
    int tx_bauds [3] = '{3, 7, 12};

    // Receiver input is either the transmitter output or a driven bit
    assign uart_rxd = loopback ? uart_txd : rxd_drive;

    uart_top UUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .s_axil_awaddr_i  (s_axil_awaddr),
        .s_axil_awvalid_i (s_axil_awvalid),
        .s_axil_awready_o (s_axil_awready),
        .s_axil_wdata_i   (s_axil_wdata),
        .s_axil_wvalid_i  (s_axil_wvalid),
        .s_axil_wready_o  (s_axil_wready),
        .s_axil_bresp_o   (s_axil_bresp),
        .s_axil_bvalid_o  (s_axil_bvalid),
        .s_axil_bready_i  (s_axil_bready),
        .s_axil_araddr_i  (s_axil_araddr),
        .s_axil_arvalid_i (s_axil_arvalid),
        .s_axil_arready_o (s_axil_arready),
        .s_axil_rdata_o   (s_axil_rdata),
        .s_axil_rresp_o   (s_axil_rresp),
        .s_axil_rvalid_o  (s_axil_rvalid),
        .s_axil_rready_i  (s_axil_rready),
        .uart_rxd_i       (uart_rxd),
        .uart_txd_o       (uart_txd),
        .uart_irq_o       (uart_irq)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------
    // Failure reporting and timeout
    // ------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            abort_run($sformatf("Timeout: tests still running after %0d cycles", cycle));
        end
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // Cycles in one frame of start, 8 data bits and stop bits
    function automatic int frame_cycles(input int baud, input int stops);
        return (baud + 1) * (9 + stops);
    endfunction

    // Line level of bit k of a frame with the data LSB first
    function automatic logic frame_bit(input logic [7:0] data, input int k, input logic stop_lvl);
        if (k == 0) return 1'b0;
        if (k <= 8) return data[k-1];
        return stop_lvl;
    endfunction

    function automatic logic [`UART_AXIL_AW-1:0] reg_addr(input uart_reg_e r);
        return {r, 2'b00};
    endfunction

    // ------------------------------------------------
    // AXI4-Lite bus tasks for calls on a falling edge
    // ------------------------------------------------
    task automatic axil_write(input logic [`UART_AXIL_AW-1:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int waited;
        waited = 0;
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        // Both ready lines are high only before the edge that accepts
        @(posedge clk);
        while (!(s_axil_awready && s_axil_wready)) begin
            waited++;
            if (waited > BUS_WAIT) begin
                abort_run($sformatf("AXI write to address %h was never accepted", addr));
            end
            @(posedge clk);
        end
        @(negedge clk);
        check("AXI write bvalid on acceptance", 32'h1, 32'(s_axil_bvalid));
        check("AXI write ready with response pending", 32'h0,
              32'({s_axil_awready, s_axil_wready}));
        resp           = s_axil_bresp;
        acc_cycle      = cycle;
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
    endtask

    task automatic axil_read(input logic [`UART_AXIL_AW-1:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int waited;
        waited = 0;
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        @(posedge clk);
        while (!s_axil_arready) begin
            waited++;
            if (waited > BUS_WAIT) begin
                abort_run($sformatf("AXI read from address %h was never accepted", addr));
            end
            @(posedge clk);
        end
        @(negedge clk);
        check("AXI read rvalid on acceptance", 32'h1, 32'(s_axil_rvalid));
        check("AXI read ready with data pending", 32'h0, 32'(s_axil_arready));
        data           = s_axil_rdata;
        resp           = s_axil_rresp;
        s_axil_arvalid = 1'b0;
    endtask

    task automatic write_ok(input string name, input uart_reg_e r, input logic [31:0] data);
        logic [1:0] resp;
        axil_write(reg_addr(r), data, resp);
        check({name, " write resp"}, 32'(RESP_OKAY), 32'(resp));
    endtask

    task automatic read_ok(input string name, input uart_reg_e r, output logic [31:0] data);
        logic [1:0] resp;
        axil_read(reg_addr(r), data, resp);
        check({name, " read resp"}, 32'(RESP_OKAY), 32'(resp));
    endtask

    // Polls STATUS until the given bit reaches the level
    task automatic wait_status(input int bit_idx, input logic level);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(reg_addr(REG_STATUS), data, resp);
        while (data[bit_idx] !== level) begin
            axil_read(reg_addr(REG_STATUS), data, resp);
        end
    endtask

    task automatic wait_irq(input logic level);
        int waited;
        waited = 0;
        while (uart_irq !== level) begin
            waited++;
            if (waited > 4) begin
                abort_run($sformatf("uart_irq_o did not go to %0b after the register write", level));
            end
            @(negedge clk);
        end
    endtask

    task automatic drive_frame(input logic [7:0] data, input logic stop_lvl, input int baud);
        for (int k = 0; k < 10; k++) begin
            rxd_drive = frame_bit(data, k, stop_lvl);
            repeat (baud + 1) @(negedge clk);
        end
        rxd_drive = 1'b1;
        repeat (baud + 1) @(negedge clk);
    endtask

    // ------------------------------------------------
    // Directed tests
    // ------------------------------------------------
    task automatic reset_state_test();
        logic [31:0] data;
        read_ok("reset BAUD", REG_BAUD, data);
        check("reset BAUD", `UART_BAUD_RST, data);
        read_ok("reset STATUS", REG_STATUS, data);
        check("reset STATUS", 32'h1, data);
        read_ok("reset CTRL", REG_CTRL, data);
        check("reset CTRL", 32'h0, data);
        read_ok("reset INT_MASK", REG_INT_MASK, data);
        check("reset INT_MASK", 32'h0, data);
        read_ok("reset RXDATA", REG_RXDATA, data);
        check("reset RXDATA byte", 32'h0, 32'(data[7:0]));
        check("reset RXDATA empty", 32'h1, 32'(data[31]));
        check("reset irq", 32'h0, 32'(uart_irq));
    endtask

    task automatic register_access_test();
        logic [31:0] val;
        logic [31:0] data;
        logic [1:0]  resp;
        for (int i = 0; i < 4; i++) begin
            val = $urandom;
            write_ok("BAUD", REG_BAUD, val);
            read_ok("BAUD", REG_BAUD, data);
            check("BAUD readback", val & 32'h0000_ffff, data);
            val = $urandom;
            write_ok("CTRL", REG_CTRL, val);
            read_ok("CTRL", REG_CTRL, data);
            check("CTRL readback", val & 32'h1, data);
            val = $urandom;
            write_ok("INT_MASK", REG_INT_MASK, val);
            read_ok("INT_MASK", REG_INT_MASK, data);
            check("INT_MASK readback", val & 32'hf, data);
        end
        for (int idx = 6; idx < 8; idx++) begin
            axil_write({3'(idx), 2'b00}, $urandom, resp);
            check($sformatf("unmapped %0d write", idx), 32'(RESP_SLVERR), 32'(resp));
            axil_read({3'(idx), 2'b00}, data, resp);
            check($sformatf("unmapped %0d read", idx), 32'(RESP_SLVERR), 32'(resp));
        end
        write_ok("restore BAUD", REG_BAUD, `UART_BAUD_RST);
        write_ok("restore CTRL", REG_CTRL, 32'h0);
        write_ok("restore INT_MASK", REG_INT_MASK, 32'h0);
    endtask

    task automatic transmit_test(input int baud, input int stops);
        logic [31:0] data;
        logic [7:0]  tx_byte;
        int          mid;
        int          target;
        string       name;
        name    = $sformatf("transmit baud %0d stops %0d", baud, stops);
        mid     = (baud + 1) / 2;
        tx_byte = 8'($urandom);
        write_ok(name, REG_BAUD, baud);
        write_ok(name, REG_CTRL, (stops == 2) ? 32'h1 : 32'h0);
        write_ok(name, REG_TXDATA, {24'h0, tx_byte});
        read_ok(name, REG_TXDATA, data);
        check({name, " busy"}, 32'h1, 32'(data[31]));
        // Start bit begins one cycle after the acceptance edge
        for (int k = 0; k < 9 + stops; k++) begin
            target = acc_cycle + 1 + k * (baud + 1) + mid;
            while (cycle < target) @(negedge clk);
            check($sformatf("%s bit %0d", name, k), 32'(frame_bit(tx_byte, k, 1'b1)),
                  32'(uart_txd));
        end
        // Transmitter stays busy through the last stop bit
        read_ok(name, REG_STATUS, data);
        check({name, " busy in last stop bit"}, 32'h0, 32'(data[0]));
        // Ready again by the middle of the bit after the frame
        target = acc_cycle + 1 + (9 + stops) * (baud + 1) + mid;
        while (cycle < target) @(negedge clk);
        read_ok(name, REG_STATUS, data);
        check({name, " ready after frame"}, 32'h1, 32'(data[0]));
    endtask

    task automatic loopback_test(input int count);
        logic [31:0] data;
        logic [7:0]  tx_byte;
        loopback = 1'b1;
        write_ok("loopback", REG_BAUD, LOOP_BAUD);
        write_ok("loopback", REG_CTRL, 32'h0);
        for (int i = 0; i < count; i++) begin
            tx_byte = 8'($urandom);
            write_ok("loopback", REG_TXDATA, {24'h0, tx_byte});
            wait_status(1, 1'b1);
            read_ok("loopback", REG_RXDATA, data);
            check("loopback byte", 32'(tx_byte), 32'(data[7:0]));
            check("loopback held", 32'h0, 32'(data[31]));
            read_ok("loopback", REG_RXDATA, data);
            check("loopback empty", 32'h1, 32'(data[31]));
            wait_status(0, 1'b1);
        end
    endtask

    task automatic error_irq_test();
        logic [31:0] data;
        logic [7:0]  first;
        logic [7:0]  second;
        loopback = 1'b0;
        write_ok("errors", REG_BAUD, ERR_BAUD);
        drive_frame(8'($urandom), 1'b0, ERR_BAUD);
        wait_status(2, 1'b1);
        read_ok("framing", REG_STATUS, data);
        check("framing STATUS", 32'h5, data);

        loopback = 1'b1;
        first    = 8'($urandom);
        second   = 8'($urandom);
        write_ok("overrun", REG_TXDATA, {24'h0, first});
        wait_status(0, 1'b1);
        write_ok("overrun", REG_TXDATA, {24'h0, second});
        wait_status(3, 1'b1);
        wait_status(0, 1'b1);
        read_ok("overrun", REG_STATUS, data);
        check("overrun STATUS", 32'hf, data);
        read_ok("overrun", REG_RXDATA, data);
        check("overrun byte", 32'(second), 32'(data[7:0]));

        write_ok("irq", REG_INT_MASK, 32'hc);
        wait_irq(1'b1);
        write_ok("irq clear", REG_STATUS, 32'hc);
        read_ok("irq clear", REG_STATUS, data);
        check("cleared STATUS", 32'h1, data);
        wait_irq(1'b0);
    endtask

    // ------------------------------------------------
    // Main sequence
    // ------------------------------------------------
    initial begin
        int seed;
        seed = $urandom(32'h078a97e8);
        foreach (tx_bauds[i]) begin
            cycle_limit += frame_cycles(tx_bauds[i], 1) + frame_cycles(tx_bauds[i], 2);
        end
        cycle_limit += LOOP_BYTES * frame_cycles(LOOP_BAUD, 1);
        // Driven frame with its idle tail and two loopback frames
        cycle_limit += frame_cycles(ERR_BAUD, 2) + 2 * frame_cycles(ERR_BAUD, 1);
        cycle_limit = 2 * cycle_limit + 2000;

        rst_n          = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b1;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b1;
        loopback       = 1'b0;
        rxd_drive      = 1'b1;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        reset_state_test();
        register_access_test();
        foreach (tx_bauds[i]) begin
            transmit_test(tx_bauds[i], 1);
            transmit_test(tx_bauds[i], 2);
        end
        loopback_test(LOOP_BYTES);
        error_irq_test();

        $display("sim passed");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+logic
logic/uart_pkg.sv
logic/uart_axil_regs.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_top.sv
dv/uart_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the UART testbench with Verilator, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing -f build.f --top-module uart_tb -o uart_sim \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/uart_sim > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "sim passed" sim.log || { echo "No pass message in sim.log"; exit 1; }
exit 0
